/* Bender.yml */
package:
  name: rv_core

sources:
  - common/rv_pkg.sv
  - design/mux_key_default.sv
  - idu/idu.sv
  - design/regfile.sv
  - exu/exu.sv
  - design/rv_core.sv
  - target: simulation
    files:
      - sim/rv_core_checker.sv
      - sim/tb_rv_core.sv

/* build.f */
common/rv_pkg.sv
design/mux_key_default.sv
idu/idu.sv
design/regfile.sv
exu/exu.sv
design/rv_core.sv
sim/rv_core_checker.sv
sim/tb_rv_core.sv

/* common/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int XLEN        = 32;
    localparam int ILEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NR_REGS     = 32;
    localparam int OPCODE_W    = 7;
    localparam int FUNCT3_W    = 3;
    localparam int INST_NUM_W  = 4;
    localparam int INST_TYPE_W = 3;
    localparam int NR_OPCODES  = 9;
    localparam int NR_FORMATS  = 6;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [ILEN-1:0]       inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [XLEN-1:0]       imm_t;
    typedef logic [OPCODE_W-1:0]   opcode_t;
    typedef logic [FUNCT3_W-1:0]   funct3_t;

    typedef enum logic [INST_NUM_W-1:0] {
        inv = 4'd0,
        auipc,
        jal,
        jalr,
        beq,
        lw,
        sw,
        addi,
        add,
        sub,
        ebreak
    } inst_num_e;

    typedef enum logic [INST_TYPE_W-1:0] {
        fmt_n = 3'd0,
        fmt_r,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j
    } inst_type_e;

    typedef struct packed {
        inst_num_e  num;
        inst_type_e itype;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        imm_t       imm;
    } dec_t;

    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_SYSTEM = 7'b1110011;

    localparam xlen_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

/* design/mux_key_default.sv */
`timescale 1ns/1ps
`default_nettype none

module mux_key_default #(
    parameter int NR_KEY   = 2,
    parameter int KEY_LEN  = 1,
    parameter int DATA_LEN = 1
) (
    output logic [DATA_LEN-1:0]                  out,
    input  wire  [KEY_LEN-1:0]                   key,
    input  wire  [DATA_LEN-1:0]                  default_out,
    input  wire  [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] lut
);

    localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

    // pairs packed as {key, data}, first listed pair sits in the top bits
    always_comb begin
        out = default_out;
        for (int k = 0; k < NR_KEY; k++) begin
            if (lut[k*PAIR_LEN+DATA_LEN +: KEY_LEN] == key) begin
                out = lut[k*PAIR_LEN +: DATA_LEN]; // higher k wins on duplicate keys
            end
        end
    end

endmodule

`default_nettype wire

/* design/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire                    clk,
    input  wire                    rst,
    input  wire rv_pkg::reg_addr_t rs1,
    input  wire rv_pkg::reg_addr_t rs2,
    output rv_pkg::xlen_t          rs1_data,
    output rv_pkg::xlen_t          rs2_data,
    input  wire                    wb_en,
    input  wire rv_pkg::reg_addr_t wb_addr,
    input  wire rv_pkg::xlen_t     wb_data
);

    import rv_pkg::*;

    xlen_t regs [NR_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < NR_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin // x0 writes dropped
            regs[wb_addr] <= wb_data;
        end
    end

    // old value on same-cycle write
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* design/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  wire                clk,
    input  wire                rst,
    input  wire rv_pkg::inst_t inst,
    output rv_pkg::xlen_t      inst_addr,
    output rv_pkg::xlen_t      data_addr,
    output rv_pkg::xlen_t      data_wdata,
    output logic               data_we,
    input  wire rv_pkg::xlen_t data_rdata,
    output logic               halt,
    output logic               illegal
);

    import rv_pkg::*;

    dec_t      dec;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    logic      wb_en;
    reg_addr_t wb_addr;
    xlen_t     wb_data;

    idu idu0 (
        .inst (inst),
        .dec  (dec)
    );

    regfile regfile0 (
        .clk      (clk),
        .rst      (rst),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    exu exu0 (
        .clk        (clk),
        .rst        (rst),
        .dec        (dec),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .data_rdata (data_rdata),
        .pc         (inst_addr), // fetch address is the pc register
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_we    (data_we),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .halt       (halt),
        .illegal    (illegal)
    );

endmodule

`default_nettype wire

/* exu/exu.sv */
`timescale 1ns/1ps
`default_nettype none

module exu (
    input  wire                 clk,
    input  wire                 rst,
    input  wire rv_pkg::dec_t   dec,
    input  wire rv_pkg::xlen_t  rs1_data,
    input  wire rv_pkg::xlen_t  rs2_data,
    input  wire rv_pkg::xlen_t  data_rdata,
    output rv_pkg::xlen_t       pc,
    output rv_pkg::xlen_t       data_addr,
    output rv_pkg::xlen_t       data_wdata,
    output logic                data_we,
    output logic                wb_en,
    output rv_pkg::reg_addr_t   wb_addr,
    output rv_pkg::xlen_t       wb_data,
    output logic                halt,
    output logic                illegal
);

    import rv_pkg::*;

    xlen_t pc_plus4;
    xlen_t pc_plus_imm;
    xlen_t rs1_plus_imm;
    xlen_t alu_res;
    xlen_t pc_next;
    logic  writes_rd;
    logic  stop;

    assign pc_plus4     = pc + 32'd4;
    assign pc_plus_imm  = pc + dec.imm;
    assign rs1_plus_imm = rs1_data + dec.imm;

    always_comb begin
        case (dec.num)
            addi:    alu_res = rs1_plus_imm;
            sub:     alu_res = rs1_data - rs2_data;
            default: alu_res = rs1_data + rs2_data;
        endcase
    end

    always_comb begin
        case (dec.num)
            jal:     pc_next = pc_plus_imm;
            jalr:    pc_next = {rs1_plus_imm[XLEN-1:1], 1'b0}; // clear bit 0
            beq:     pc_next = (rs1_data == rs2_data) ? pc_plus_imm : pc_plus4;
            default: pc_next = pc_plus4;
        endcase
    end

    always_comb begin
        case (dec.num)
            auipc:     wb_data = pc_plus_imm;
            jal, jalr: wb_data = pc_plus4; // link
            lw:        wb_data = data_rdata;
            default:   wb_data = alu_res;
        endcase
    end

    assign writes_rd = dec.num inside {auipc, jal, jalr, lw, addi, add, sub};
    assign stop      = (dec.num == ebreak) || (dec.num == inv);

    assign wb_en      = writes_rd && !halt && dec.rd != '0;
    assign wb_addr    = dec.rd;
    assign data_addr  = rs1_plus_imm;
    assign data_wdata = rs2_data;
    assign data_we    = (dec.num == sw) && !halt;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= RESET_PC;
            halt    <= 1'b0;
            illegal <= 1'b0;
        end else if (!halt) begin
            if (stop) begin
                halt    <= 1'b1; // pc stays on the stopping word
                illegal <= (dec.num == inv);
            end else begin
                pc <= pc_next;
            end
        end
    end

endmodule

`default_nettype wire

/* idu/idu.sv */
`timescale 1ns/1ps
`default_nettype none

module idu (
    input  wire rv_pkg::inst_t inst,
    output rv_pkg::dec_t       dec
);

    import rv_pkg::*;

    opcode_t                opcode;
    funct3_t                funct3;
    logic [INST_NUM_W-1:0]  beq_num;
    logic [INST_NUM_W-1:0]  lw_num;
    logic [INST_NUM_W-1:0]  sw_num;
    logic [INST_NUM_W-1:0]  addi_num;
    logic [INST_NUM_W-1:0]  add_num;
    logic [INST_NUM_W-1:0]  num_raw;
    logic [INST_TYPE_W-1:0] type_raw;
    imm_t                   imm;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    // funct3 stage, one lookup per opcode class
    mux_key_default #(.NR_KEY(1), .KEY_LEN(FUNCT3_W), .DATA_LEN(INST_NUM_W)) mux_beq_num (
        .out(beq_num), .key(funct3), .default_out(inv), .lut({3'b000, beq})
    );

    mux_key_default #(.NR_KEY(1), .KEY_LEN(FUNCT3_W), .DATA_LEN(INST_NUM_W)) mux_lw_num (
        .out(lw_num), .key(funct3), .default_out(inv), .lut({3'b010, lw})
    );

    mux_key_default #(.NR_KEY(1), .KEY_LEN(FUNCT3_W), .DATA_LEN(INST_NUM_W)) mux_sw_num (
        .out(sw_num), .key(funct3), .default_out(inv), .lut({3'b010, sw})
    );

    mux_key_default #(.NR_KEY(1), .KEY_LEN(FUNCT3_W), .DATA_LEN(INST_NUM_W)) mux_addi_num (
        .out(addi_num), .key(funct3), .default_out(inv), .lut({3'b000, addi})
    );

    mux_key_default #(.NR_KEY(1), .KEY_LEN(FUNCT3_W), .DATA_LEN(INST_NUM_W)) mux_add_num (
        .out(add_num), .key(funct3), .default_out(inv),
        .lut({3'b000, (inst[30] ? sub : add)}) // bit 30 splits add/sub
    );

    mux_key_default #(
        .NR_KEY(NR_OPCODES), .KEY_LEN(OPCODE_W), .DATA_LEN(INST_NUM_W)
    ) mux_inst_num (
        .out(num_raw),
        .key(opcode),
        .default_out(inv),
        .lut({OP_AUIPC,  auipc,
              OP_JAL,    jal,
              OP_JALR,   jalr,
              OP_BRANCH, beq_num,
              OP_LOAD,   lw_num,
              OP_STORE,  sw_num,
              OP_IMM,    addi_num,
              OP_REG,    add_num,
              OP_SYSTEM, ebreak})
    );

    mux_key_default #(
        .NR_KEY(NR_OPCODES), .KEY_LEN(OPCODE_W), .DATA_LEN(INST_TYPE_W)
    ) mux_inst_type (
        .out(type_raw),
        .key(opcode),
        .default_out(fmt_n),
        .lut({OP_AUIPC, fmt_u, OP_JAL, fmt_j, OP_JALR, fmt_i,
              OP_BRANCH, fmt_b, OP_LOAD, fmt_i, OP_STORE, fmt_s,
              OP_IMM, fmt_i, OP_REG, fmt_r, OP_SYSTEM, fmt_i})
    );

    mux_key_default #(
        .NR_KEY(NR_FORMATS), .KEY_LEN(INST_TYPE_W), .DATA_LEN(XLEN)
    ) mux_imm (
        .out(imm),
        .key(type_raw),
        .default_out('0), // fmt_n
        .lut({fmt_r, 32'b0,
              fmt_i, {{20{inst[31]}}, inst[31:20]},
              fmt_s, {{20{inst[31]}}, inst[31:25], inst[11:7]},
              fmt_b, {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0},
              fmt_u, {inst[31:12], 12'b0},
              fmt_j, {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}})
    );

    always_comb begin
        dec.num   = inst_num_e'(num_raw);
        dec.itype = inst_type_e'(type_raw);
        dec.rd    = inst[11:7];
        dec.rs1   = inst[19:15];
        dec.rs2   = inst[24:20];
        dec.imm   = imm;
    end

endmodule

`default_nettype wire

/* sim/rv_core_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_checker (
    input wire                    clk,
    input wire                    rst,
    input wire                    halt,
    input wire                    illegal,
    input wire                    data_we,
    input wire rv_pkg::xlen_t     inst_addr,
    input wire                    wb_en,
    input wire rv_pkg::reg_addr_t wb_addr
);

    int err_count = 0; // read by the testbench

    halt_sticky: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
        else begin
            $error("halt dropped without reset");
            err_count++;
        end

    no_store_halted: assert property (@(posedge clk) disable iff (rst) halt |-> !data_we)
        else begin
            $error("store while halted");
            err_count++;
        end

    pc_hold: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(inst_addr))
        else begin
            $error("inst_addr moved while halted");
            err_count++;
        end

    illegal_halts: assert property (@(posedge clk) disable iff (rst) illegal |-> halt)
        else begin
            $error("illegal without halt");
            err_count++;
        end

    no_x0_write: assert property (@(posedge clk) disable iff (rst) !(wb_en && wb_addr == '0))
        else begin
            $error("write-back enabled for x0");
            err_count++;
        end

endmodule

bind rv_core rv_core_checker checker0 (
    .clk       (clk),
    .rst       (rst),
    .halt      (halt),
    .illegal   (illegal),
    .data_we   (data_we),
    .inst_addr (inst_addr),
    .wb_en     (wb_en),
    .wb_addr   (wb_addr)
);

`default_nettype wire

/* sim/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int          CLK_PERIOD  = 20;
    localparam int          RST_CYCLES  = 3;
    localparam int          NR_PROGS    = 8;
    localparam int          PROG_CYCLES = 200;
    localparam int          MEM_WORDS   = 256;
    localparam logic [31:0] EBREAK      = 32'h0010_0073;
    localparam logic [6:0]  OPC_IMM     = 7'b0010011;
    localparam logic [6:0]  OPC_LOAD    = 7'b0000011;
    localparam logic [6:0]  OPC_JALR    = 7'b1100111;

    logic        clk;
    logic        rst;
    logic [31:0] inst;
    logic [31:0] inst_addr;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [31:0] data_rdata;
    logic        data_we;
    logic        halt;
    logic        illegal;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];
    logic [31:0] prog [$];
    string       test_name;

    // architectural model state and its per-instruction results
    logic [31:0] m_x [32];
    logic [31:0] m_mem [MEM_WORDS];
    logic [31:0] m_pc;
    logic        m_halt;
    logic        m_ill;
    logic [31:0] e_next;
    logic [31:0] e_wb_val;
    logic [31:0] e_addr;
    logic [31:0] e_wdata;
    logic [4:0]  e_rd;
    logic        e_wb_en;
    logic        e_we;
    logic        e_acc;
    logic        e_stop;
    logic        e_ill;

    rv_core dut0 (
        .clk        (clk),
        .rst        (rst),
        .inst       (inst),
        .inst_addr  (inst_addr),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_we    (data_we),
        .data_rdata (data_rdata),
        .halt       (halt),
        .illegal    (illegal)
    );

    assign inst       = imem[inst_addr[9:2]];
    assign data_rdata = dmem[data_addr[9:2]];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    function automatic logic [31:0] enc_i(logic [6:0] op, logic [2:0] f3, int rd, int rs1,
                                          int imm);
        logic [31:0] v;
        v = imm;
        return {v[11:0], 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_rr(logic is_sub, int rd, int rs1, int rs2);
        return {1'b0, is_sub, 5'b0, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_sw(int rs2, int rs1, int imm);
        logic [31:0] v;
        v = imm;
        return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(logic [2:0] f3, int rs1, int rs2, int imm);
        logic [31:0] v;
        v = imm;
        return {v[12], v[10:5], 5'(rs2), 5'(rs1), f3, v[4:1], v[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(int rd, int imm);
        logic [31:0] v;
        v = imm;
        return {v[20], v[10:1], v[11], v[19:12], 5'(rd), 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_auipc(int rd, int imm20);
        logic [31:0] v;
        v = imm20;
        return {v[19:0], 5'(rd), 7'b0010111};
    endfunction

    task automatic model_eval();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        w        = imem[m_pc[9:2]];
        a        = m_x[w[19:15]];
        b        = m_x[w[24:20]];
        imm_i    = {{20{w[31]}}, w[31:20]};
        imm_s    = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b    = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_j    = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        e_rd     = w[11:7];
        e_next   = m_pc + 32'd4;
        e_wb_en  = 1'b0;
        e_wb_val = '0;
        e_we     = 1'b0;
        e_acc    = 1'b0;
        e_addr   = '0;
        e_wdata  = b;
        e_stop   = 1'b0;
        e_ill    = 1'b0;
        case (w[6:0])
            7'b0010111: begin // auipc
                e_wb_en  = 1'b1;
                e_wb_val = m_pc + {w[31:12], 12'h000};
            end
            7'b1101111: begin // jal
                e_wb_en  = 1'b1;
                e_wb_val = m_pc + 32'd4;
                e_next   = m_pc + imm_j;
            end
            7'b1100111: begin // jalr
                e_wb_en  = 1'b1;
                e_wb_val = m_pc + 32'd4;
                e_next   = (a + imm_i) & 32'hffff_fffe;
            end
            7'b1100011: begin // only beq
                e_ill = (w[14:12] != 3'b000);
                if (a == b) begin
                    e_next = m_pc + imm_b;
                end
            end
            7'b0000011: begin // lw
                e_ill    = (w[14:12] != 3'b010);
                e_acc    = 1'b1;
                e_addr   = a + imm_i;
                e_wb_en  = 1'b1;
                e_wb_val = m_mem[e_addr[9:2]];
            end
            7'b0100011: begin // sw
                e_ill  = (w[14:12] != 3'b010);
                e_acc  = 1'b1;
                e_we   = 1'b1;
                e_addr = a + imm_s;
            end
            7'b0010011: begin // addi
                e_ill    = (w[14:12] != 3'b000);
                e_wb_en  = 1'b1;
                e_wb_val = a + imm_i;
            end
            7'b0110011: begin // add, sub
                e_ill    = (w[14:12] != 3'b000);
                e_wb_en  = 1'b1;
                e_wb_val = w[30] ? a - b : a + b;
            end
            7'b1110011: e_stop = 1'b1; // ebreak
            default:    e_ill = 1'b1;
        endcase
        if (e_ill) begin
            e_stop  = 1'b1;
            e_wb_en = 1'b0;
            e_we    = 1'b0;
            e_acc   = 1'b0;
        end
        if (e_rd == 5'd0) begin
            e_wb_en = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 32; k++) begin
                m_x[k] = '0;
            end
            m_pc   = 32'h0;
            m_halt = 1'b0;
            m_ill  = 1'b0;
        end else if (!m_halt) begin
            model_eval();
            if (e_stop) begin
                m_halt = 1'b1;
                m_ill  = e_ill;
            end else begin
                if (e_wb_en) begin
                    m_x[e_rd] = e_wb_val;
                end
                if (e_we) begin
                    m_mem[e_addr[9:2]] = e_wdata;
                end
                m_pc = e_next;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && data_we) begin
            dmem[data_addr[9:2]] <= data_wdata;
        end
    end

    task automatic check_outputs();
        model_eval();
        check_value("inst_addr", m_pc, inst_addr);
        check_value("halt", m_halt, halt);
        check_value("illegal", m_ill, illegal);
        check_value("data_we", !m_halt && e_we, data_we);
        if (!m_halt && e_acc) begin
            check_value("data_addr", e_addr, data_addr);
        end
        if (data_we) begin
            check_value("data_wdata", e_wdata, data_wdata);
        end
        assert (dut0.checker0.err_count == 0) else begin
            $display("bound checker in %s reported a property violation", test_name);
            stop_with_failure();
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check_outputs();
        end
    end

    task automatic start_program(string name);
        @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        test_name = name;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i]  = (i < prog.size()) ? prog[i] : {25'(i), 7'h7f}; // illegal filler
            dmem[i]  = 32'(i) * 32'h9e37_79b9 + 32'h0bad_f00d;
            m_mem[i] = dmem[i];
        end
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset inst_addr", 32'h0, inst_addr);
        check_value("reset halt", 1'b0, halt);
        check_value("reset illegal", 1'b0, illegal);
    endtask

    task automatic finish_program();
        do @(negedge clk); while (!halt);
        repeat (4) @(negedge clk); // halted core must stay put
        for (int k = 0; k < 32; k++) begin
            check_value($sformatf("x%0d", k), m_x[k], dut0.regfile0.regs[k]);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_value($sformatf("dmem[%0d]", i), m_mem[i], dmem[i]);
        end
    endtask

    task automatic build_arith();
        int rd;
        int rs1;
        int rs2;
        int imm;
        prog.delete();
        prog.push_back(enc_i(OPC_IMM, 3'b000, 0, 5, 123)); // aimed at x0
        for (int k = 0; k < 40; k++) begin
            rd  = $urandom % 32;
            rs1 = $urandom % 32;
            rs2 = $urandom % 32;
            imm = $urandom % 4096;
            case ($urandom % 3)
                0:       prog.push_back(enc_i(OPC_IMM, 3'b000, rd, rs1, imm));
                1:       prog.push_back(enc_rr(1'b0, rd, rs1, rs2));
                default: prog.push_back(enc_rr(1'b1, rd, rs1, rs2));
            endcase
        end
        for (int r = 0; r < 32; r++) begin
            prog.push_back(enc_sw(r, 0, 4 * r));
        end
        prog.push_back(EBREAK);
    endtask

    task automatic build_ldst();
        int base;
        int off;
        prog.delete();
        for (int k = 0; k < 8; k++) begin
            base = 512 + 4 * int'($urandom % 64);
            off  = 4 * int'($urandom % 128) - 256; // backward and forward offsets
            prog.push_back(enc_i(OPC_IMM, 3'b000, 1, 0, base));
            prog.push_back(enc_i(OPC_IMM, 3'b000, 2, 0, int'($urandom % 4096)));
            prog.push_back(enc_sw(2, 1, off));
            prog.push_back(enc_i(OPC_LOAD, 3'b010, 3, 1, off));
            prog.push_back(enc_sw(3, 0, 4 * k));
            prog.push_back(enc_i(OPC_LOAD, 3'b010, 4, 0, 4 * int'($urandom % 256)));
        end
        prog.push_back(EBREAK);
    endtask

    task automatic build_control();
        prog = '{
            enc_auipc(5, 32'h12345),
            enc_jal(1, 12),                     // 4 -> 16
            enc_i(OPC_IMM, 3'b000, 7, 7, 1),
            enc_b(3'b000, 0, 0, 24),            // 12 -> 36
            enc_i(OPC_IMM, 3'b000, 8, 0, 3),
            enc_b(3'b000, 8, 0, 8),             // not taken
            enc_i(OPC_IMM, 3'b000, 9, 0, 49),   // odd jalr target
            enc_i(OPC_JALR, 3'b000, 2, 9, 0),
            EBREAK,
            enc_sw(1, 0, 0),
            enc_sw(2, 0, 4),
            enc_sw(5, 0, 8),
            enc_b(3'b000, 7, 0, -40),           // back to 8 once
            enc_auipc(10, 0),
            enc_sw(10, 0, 12),
            enc_sw(7, 0, 16),
            EBREAK
        };
    endtask

    initial begin
        void'($urandom(61348));
        rst       = 1'b1;
        test_name = "init";
        build_arith();
        start_program("arith");
        finish_program();
        build_ldst();
        start_program("load_store");
        finish_program();
        build_control();
        start_program("control");
        finish_program();
        prog = '{enc_i(OPC_IMM, 3'b000, 1, 0, 7), enc_sw(1, 0, 0), EBREAK,
                 enc_sw(1, 0, 4), enc_sw(1, 0, 8)};
        start_program("ebreak");
        finish_program();
        prog = '{enc_i(OPC_IMM, 3'b000, 1, 0, 5), 32'hffff_ffff, enc_sw(1, 0, 0),
                 enc_i(OPC_IMM, 3'b000, 2, 0, 9)};
        start_program("bad_opcode");
        finish_program();
        prog = '{enc_i(OPC_IMM, 3'b000, 1, 0, 5), enc_b(3'b001, 1, 0, 8),
                 enc_sw(1, 0, 0), EBREAK};
        start_program("bad_branch");
        finish_program();
        prog = '{enc_i(OPC_IMM, 3'b000, 1, 1, 1), enc_b(3'b000, 0, 0, -4)};
        start_program("endless_loop");
        repeat (30) @(negedge clk);
        build_control();
        start_program("control_after_reset"); // reset lands mid-loop
        finish_program();
        if (dut0.checker0.err_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("bound checker reported a property violation");
            stop_with_failure();
        end
    end

    initial begin
        #(NR_PROGS * (PROG_CYCLES + RST_CYCLES + 2) * CLK_PERIOD);
        $display("timeout in %s, the core did not halt in time", test_name);
        stop_with_failure();
    end

endmodule

`default_nettype wire
